//--- Makefile
TOP = core_io_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f core_io.f

# The error limit lets the run go on past failed assertions to the closing line
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- core_io.f
src/io_map_pkg.sv
src/io_bus_pkg.sv
src/io_regs.sv
src/interval_timer.sv
src/dram_recv_flags.sv
src/irq_ctrl.sv
src/core_io_top.sv
test/tb_clock_gen.sv
test/core_io_assertions.sv
test/core_io_tb.sv

//--- src/core_io_top.sv
`timescale 1ns/1ps

module core_io_top (
  input  logic                   clk,
  input  logic                   rst,

  // Core data bus, internal I/O window
  input  io_bus_pkg::io_req_t    io_req,
  output logic                   io_cmd_ready,
  output logic                   io_rsp_valid,
  output io_bus_pkg::word_t      io_rsp_data,

  // Incoming descriptor
  input  io_bus_pkg::desc_t      in_desc,
  input  logic                   in_desc_valid,
  output logic                   in_desc_taken,

  // Outgoing descriptor
  output io_bus_pkg::desc_t      out_desc,
  output logic                   out_desc_valid,
  output io_bus_pkg::dram_addr_t out_desc_dram_addr,
  input  logic                   out_desc_ready,

  input  io_bus_pkg::core_id_t   core_id,
  input  io_bus_pkg::timer_val_t timer,

  input  io_bus_pkg::dram_tag_t  recv_dram_tag,
  input  logic                   recv_dram_tag_valid,

  // Interrupts
  input  logic                   poke_int,
  input  logic                   evict_int,
  output logic                   poke_int_ack,
  output logic                   evict_int_ack,
  output logic                   core_irq
);

  import io_bus_pkg::*;

  io_ctrl_t  io_ctrl;
  logic      timer_irq;
  word_t     flags;
  logic      flag_any;
  irq_mask_t irq_mask;
  word_t     int_flags;

  io_regs i_io_regs (
    .clk                (clk),
    .rst                (rst),
    .io_req             (io_req),
    .io_cmd_ready       (io_cmd_ready),
    .io_rsp_valid       (io_rsp_valid),
    .io_rsp_data        (io_rsp_data),
    .io_ctrl            (io_ctrl),
    .in_desc            (in_desc),
    .in_desc_valid      (in_desc_valid),
    .in_desc_taken      (in_desc_taken),
    .out_desc           (out_desc),
    .out_desc_valid     (out_desc_valid),
    .out_desc_dram_addr (out_desc_dram_addr),
    .out_desc_ready     (out_desc_ready),
    .core_id            (core_id),
    .timer              (timer),
    .flags              (flags),
    .irq_mask           (irq_mask),
    .int_flags          (int_flags)
  );

  interval_timer i_interval_timer (
    .clk       (clk),
    .rst       (rst),
    .io_ctrl   (io_ctrl),
    .timer_irq (timer_irq)
  );

  dram_recv_flags i_dram_recv_flags (
    .clk                 (clk),
    .rst                 (rst),
    .io_ctrl             (io_ctrl),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .flags               (flags),
    .flag_any            (flag_any)
  );

  irq_ctrl i_irq_ctrl (
    .clk           (clk),
    .rst           (rst),
    .io_ctrl       (io_ctrl),
    .timer_irq     (timer_irq),
    .flag_any      (flag_any),
    .in_desc_valid (in_desc_valid),
    .poke_int      (poke_int),
    .evict_int     (evict_int),
    .irq_mask      (irq_mask),
    .int_flags     (int_flags),
    .core_irq      (core_irq),
    .poke_int_ack  (poke_int_ack),
    .evict_int_ack (evict_int_ack)
  );

endmodule

//--- src/dram_recv_flags.sv
`timescale 1ns/1ps

module dram_recv_flags (
  input  logic                  clk,
  input  logic                  rst,
  input  io_bus_pkg::io_ctrl_t  io_ctrl,
  input  io_bus_pkg::dram_tag_t recv_dram_tag,
  input  logic                  recv_dram_tag_valid,
  output io_bus_pkg::word_t     flags,
  output logic                  flag_any
);

  import io_bus_pkg::*;

  dram_tag_t tag_q;
  logic      tag_valid_q;
  dram_tag_t clr_idx;

  // Input stage for timing, the flag sets one edge later
  always_ff @(posedge clk) begin
    tag_q <= recv_dram_tag;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_valid_q <= 1'b0;
    end else begin
      tag_valid_q <= recv_dram_tag_valid;
    end
  end

  assign clr_idx = io_ctrl.wdata[4:0];

  ////////////////////////////////////////////////////////////
  // Flag register
  ////////////////////////////////////////////////////////////

  // Later assignments take priority: write, then clear, then tag set
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      if (io_ctrl.flag_wr) begin
        for (int i = 0; i < 4; i++) begin
          if (io_ctrl.strb[i]) begin
            flags[i*8 +: 8] <= io_ctrl.wdata[i*8 +: 8];
          end
        end
      end
      if (io_ctrl.flag_clr) begin
        flags[clr_idx] <= 1'b0;
      end
      if (tag_valid_q) begin
        flags[tag_q] <= 1'b1;
      end
      // Tag 0 is reserved
      flags[0] <= 1'b0;
    end
  end

  assign flag_any = |flags;

endmodule

//--- src/interval_timer.sv
`timescale 1ns/1ps

module interval_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  io_bus_pkg::io_ctrl_t io_ctrl,
  output logic                 timer_irq
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  word_t step_q;
  word_t count_q;

  // Step register, written per byte lane
  always_ff @(posedge clk) begin
    if (rst) begin
      step_q <= timer_step_reset;
    end else if (io_ctrl.timer_step_wr) begin
      for (int i = 0; i < 4; i++) begin
        if (io_ctrl.strb[i]) begin
          step_q[i*8 +: 8] <= io_ctrl.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Period is step+1 cycles, a new step restarts the count
  always_ff @(posedge clk) begin
    if (rst || io_ctrl.timer_step_wr) begin
      count_q   <= '0;
      timer_irq <= 1'b0;
    end else if (count_q == step_q) begin
      count_q   <= '0;
      timer_irq <= 1'b1;
    end else begin
      count_q <= count_q + 32'd1;
      if (io_ctrl.ack && io_ctrl.wdata[irq_timer_bit]) begin
        timer_irq <= 1'b0;
      end
    end
  end

endmodule

//--- src/io_bus_pkg.sv
package io_bus_pkg;

  typedef logic [31:0] word_t;
  typedef logic [63:0] desc_t;
  typedef logic [63:0] dram_addr_t;
  typedef logic [4:0]  dram_tag_t;
  typedef logic [15:0] irq_mask_t;
  typedef logic [7:0]  core_id_t;
  typedef logic [63:0] timer_val_t;
  typedef logic [7:0]  io_byte_addr_t;
  typedef logic [3:0]  strb_t;
  // 0 byte, 1 half-word, 2 word
  typedef logic [1:0]  io_size_t;

  // Data-bus request from the core
  typedef struct packed {
    logic          valid;
    logic          write;
    io_byte_addr_t addr;
    word_t         wdata;
    io_size_t      size;
  } io_req_t;

  // Single-cycle write pulses from the bus front end
  typedef struct packed {
    logic  timer_step_wr;
    logic  flag_wr;
    strb_t strb;
    logic  flag_clr;
    logic  mask_wr;
    logic  ack;
    word_t wdata;
  } io_ctrl_t;

endpackage

//--- src/io_map_pkg.sv
package io_map_pkg;

  typedef logic [5:0] io_addr_t;

  ////////////////////////////////////////////////////////////
  // Write word addresses
  ////////////////////////////////////////////////////////////

  localparam io_addr_t send_desc_addr_l = 6'b000010;
  localparam io_addr_t send_desc_addr_h = 6'b000011;
  localparam io_addr_t wr_dram_addr_l   = 6'b000100;
  localparam io_addr_t wr_dram_addr_h   = 6'b000101;
  localparam io_addr_t timer_stp_addr   = 6'b000111;
  localparam io_addr_t dram_flag_addr   = 6'b001000;
  // Type write doubles as the send strobe
  localparam io_addr_t send_desc_type   = 6'b001010;
  localparam io_addr_t rd_desc_strb     = 6'b001011;
  localparam io_addr_t dram_flag_rst    = 6'b001100;
  localparam io_addr_t mask_wr          = 6'b001110;
  localparam io_addr_t interrupt_ack    = 6'b001111;

  ////////////////////////////////////////////////////////////
  // Read word addresses
  ////////////////////////////////////////////////////////////

  localparam io_addr_t rd_desc_addr_l   = 6'b100000;
  localparam io_addr_t rd_desc_addr_h   = 6'b100001;
  localparam io_addr_t rd_d_flags_addr  = 6'b100010;
  localparam io_addr_t rd_stat_addr     = 6'b100011;
  localparam io_addr_t rd_id_addr       = 6'b100100;
  localparam io_addr_t rd_timer_l_addr  = 6'b100101;
  localparam io_addr_t rd_timer_h_addr  = 6'b100110;
  localparam io_addr_t rd_int_f_addr    = 6'b100111;
  localparam io_addr_t rd_mask          = 6'b101000;

  // Bit positions in the interrupt flags word and the mask
  localparam int irq_timer_bit   = 0;
  localparam int irq_in_desc_bit = 1;
  localparam int irq_dram_bit    = 2;
  localparam int irq_poke_bit    = 4;
  localparam int irq_evict_bit   = 5;

  // Reset values
  localparam logic [15:0] mask_reset       = 16'hFFF0;
  localparam logic [31:0] timer_step_reset = 32'd1;

endpackage

//--- src/io_regs.sv
`timescale 1ns/1ps

module io_regs (
  input  logic                   clk,
  input  logic                   rst,

  // Core data bus
  input  io_bus_pkg::io_req_t    io_req,
  output logic                   io_cmd_ready,
  output logic                   io_rsp_valid,
  output io_bus_pkg::word_t      io_rsp_data,
  output io_bus_pkg::io_ctrl_t   io_ctrl,

  // Descriptors
  input  io_bus_pkg::desc_t      in_desc,
  input  logic                   in_desc_valid,
  output logic                   in_desc_taken,
  output io_bus_pkg::desc_t      out_desc,
  output logic                   out_desc_valid,
  output io_bus_pkg::dram_addr_t out_desc_dram_addr,
  input  logic                   out_desc_ready,

  // Read-only sources
  input  io_bus_pkg::core_id_t   core_id,
  input  io_bus_pkg::timer_val_t timer,
  input  io_bus_pkg::word_t      flags,
  input  io_bus_pkg::irq_mask_t  irq_mask,
  input  io_bus_pkg::word_t      int_flags
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  io_addr_t   word_addr;
  strb_t      strb;
  logic       send_req;
  logic       wr_acc;
  logic       rd_acc;
  word_t      rd_data;

  desc_t      out_data_q;
  logic [3:0] out_type_q;
  dram_addr_t dram_addr_q;
  logic       out_valid_q;

  ////////////////////////////////////////////////////////////
  // Decode and handshake
  ////////////////////////////////////////////////////////////

  assign word_addr = io_req.addr[7:2];

  // Byte lanes from access size and low address bits
  always_comb begin
    case (io_req.size)
      2'd0:    strb = 4'b0001 << io_req.addr[1:0];
      2'd1:    strb = 4'b0011 << io_req.addr[1:0];
      default: strb = 4'b1111;
    endcase
  end

  // Only a send can stall, and only while the output is blocked
  assign send_req     = io_req.valid && io_req.write && (word_addr == send_desc_type);
  assign io_cmd_ready = !send_req || out_desc_ready;

  assign wr_acc = io_req.valid && io_req.write && io_cmd_ready;
  assign rd_acc = io_req.valid && !io_req.write && io_cmd_ready;

  always_comb begin
    io_ctrl.timer_step_wr = wr_acc && (word_addr == timer_stp_addr);
    io_ctrl.flag_wr       = wr_acc && (word_addr == dram_flag_addr);
    io_ctrl.strb          = strb;
    io_ctrl.flag_clr      = wr_acc && (word_addr == dram_flag_rst);
    io_ctrl.mask_wr       = wr_acc && (word_addr == mask_wr);
    io_ctrl.ack           = wr_acc && (word_addr == interrupt_ack);
    io_ctrl.wdata         = io_req.wdata;
  end

  ////////////////////////////////////////////////////////////
  // Outgoing descriptor
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_acc) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          case (word_addr)
            send_desc_addr_l: out_data_q[i*8 +: 8]       <= io_req.wdata[i*8 +: 8];
            send_desc_addr_h: out_data_q[32+i*8 +: 8]    <= io_req.wdata[i*8 +: 8];
            wr_dram_addr_l:   dram_addr_q[i*8 +: 8]      <= io_req.wdata[i*8 +: 8];
            wr_dram_addr_h:   dram_addr_q[32+i*8 +: 8]   <= io_req.wdata[i*8 +: 8];
            default: begin
            end
          endcase
        end
      end
      // Type sits in the low nibble of lane 0
      if (word_addr == send_desc_type && strb[0]) begin
        out_type_q <= io_req.wdata[3:0];
      end
    end
  end

  // A new send wins over the take of the previous one
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (send_req && wr_acc) begin
      out_valid_q <= 1'b1;
    end else if (out_valid_q && out_desc_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  assign out_desc           = {out_type_q, out_data_q[59:0]};
  assign out_desc_valid     = out_valid_q;
  assign out_desc_dram_addr = dram_addr_q;

  assign in_desc_taken = wr_acc && (word_addr == rd_desc_strb) && io_req.wdata[0];

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (word_addr)
      rd_desc_addr_l:  rd_data = in_desc[31:0];
      rd_desc_addr_h:  rd_data = in_desc[63:32];
      rd_d_flags_addr: rd_data = flags;
      rd_stat_addr:    rd_data = {23'd0, out_desc_ready, 7'd0, in_desc_valid};
      rd_id_addr:      rd_data = {24'd0, core_id};
      rd_timer_l_addr: rd_data = timer[31:0];
      rd_timer_h_addr: rd_data = timer[63:32];
      rd_int_f_addr:   rd_data = int_flags;
      rd_mask:         rd_data = {16'd0, irq_mask};
      default:         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      io_rsp_data <= rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rsp_valid <= 1'b0;
    end else begin
      io_rsp_valid <= rd_acc;
    end
  end

endmodule

//--- src/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  io_bus_pkg::io_ctrl_t  io_ctrl,

  // Event sources
  input  logic                  timer_irq,
  input  logic                  flag_any,
  input  logic                  in_desc_valid,
  input  logic                  poke_int,
  input  logic                  evict_int,

  output io_bus_pkg::irq_mask_t irq_mask,
  output io_bus_pkg::word_t     int_flags,
  output logic                  core_irq,
  output logic                  poke_int_ack,
  output logic                  evict_int_ack
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  logic irq_d;

  // Mask written per byte lane
  always_ff @(posedge clk) begin
    if (rst) begin
      irq_mask <= mask_reset;
    end else if (io_ctrl.mask_wr) begin
      for (int i = 0; i < 2; i++) begin
        if (io_ctrl.strb[i]) begin
          irq_mask[i*8 +: 8] <= io_ctrl.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Unmasked view for software with each source at its own bit
  always_comb begin
    int_flags                  = '0;
    int_flags[irq_timer_bit]   = timer_irq;
    int_flags[irq_in_desc_bit] = in_desc_valid;
    int_flags[irq_dram_bit]    = flag_any;
    int_flags[irq_poke_bit]    = poke_int;
    int_flags[irq_evict_bit]   = evict_int;
  end

  ////////////////////////////////////////////////////////////
  // Core interrupt and acks
  ////////////////////////////////////////////////////////////

  // Sources stay high until served, so an ack drops the line for
  // one cycle and lets it come back if something is still pending
  assign irq_d = !io_ctrl.ack && (|(int_flags[15:0] & irq_mask));

  always_ff @(posedge clk) begin
    if (rst) begin
      core_irq <= 1'b0;
    end else begin
      core_irq <= irq_d;
    end
  end

  assign poke_int_ack  = io_ctrl.ack && io_ctrl.wdata[irq_poke_bit];
  assign evict_int_ack = io_ctrl.ack && io_ctrl.wdata[irq_evict_bit];

endmodule

//--- test/core_io_assertions.sv
`timescale 1ns/1ps

module core_io_assertions (
  input logic                  clk,
  input logic                  rst,
  input io_bus_pkg::io_req_t   io_req,
  input logic                  io_cmd_ready,
  input logic                  io_rsp_valid,
  input logic                  in_desc_taken,
  input logic                  out_desc_valid,
  input logic                  out_desc_ready,
  input io_bus_pkg::word_t     flags,
  input logic                  timer_irq,
  input logic                  in_desc_valid,
  input logic                  poke_int,
  input logic                  evict_int,
  input io_bus_pkg::irq_mask_t irq_mask,
  input logic                  core_irq,
  input logic                  poke_int_ack,
  input logic                  evict_int_ack
);

  import io_map_pkg::*;

  int   fail_count = 0;

  logic        rd_acc;
  logic        wr_acc;
  logic        send_stall;
  logic        ack_wr;
  logic [15:0] sources;
  logic        irq_pending;

  assign rd_acc      = io_req.valid && !io_req.write && io_cmd_ready;
  assign wr_acc      = io_req.valid && io_req.write && io_cmd_ready;
  assign send_stall  = io_req.valid && io_req.write && !out_desc_ready &&
                       (io_req.addr[7:2] == send_desc_type);
  assign ack_wr      = wr_acc && (io_req.addr[7:2] == interrupt_ack);

  // Event sources in the register map order
  assign sources     = {10'd0, evict_int, poke_int, 1'b0, (flags != '0),
                        in_desc_valid, timer_irq};
  assign irq_pending = |(sources & irq_mask);

  ////////////////////////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////////////////////////

  rsp_after_read: assert property (@(posedge clk) disable iff (rst)
    rd_acc |=> io_rsp_valid) else begin
    $error("read accepted but no response on the next cycle");
    fail_count++;
  end

  no_rsp_otherwise: assert property (@(posedge clk) disable iff (rst)
    !rd_acc |=> !io_rsp_valid) else begin
    $error("response without an accepted read");
    fail_count++;
  end

  // Blocked send is held off and leaves the output untouched
  send_held: assert property (@(posedge clk) disable iff (rst)
    send_stall |-> !io_cmd_ready ##1 (out_desc_valid == $past(out_desc_valid))) else begin
    $error("send accepted while out_desc_ready was low");
    fail_count++;
  end

  out_valid_holds: assert property (@(posedge clk) disable iff (rst)
    out_desc_valid && !out_desc_ready |=> out_desc_valid) else begin
    $error("out_desc_valid dropped before the descriptor was taken");
    fail_count++;
  end

  taken_pulse: assert property (@(posedge clk) disable iff (rst)
    in_desc_taken == (wr_acc && (io_req.addr[7:2] == rd_desc_strb) && io_req.wdata[0]))
    else begin
    $error("in_desc_taken does not follow the strobe write");
    fail_count++;
  end

  ////////////////////////////////////////////////////////////
  // Flags and interrupts
  ////////////////////////////////////////////////////////////

  flag0_zero: assert property (@(posedge clk) disable iff (rst) !flags[0]) else begin
    $error("DRAM flag bit 0 is set");
    fail_count++;
  end

  irq_raise: assert property (@(posedge clk) disable iff (rst)
    !ack_wr && irq_pending |=> core_irq) else begin
    $error("core_irq not raised by a pending unmasked source");
    fail_count++;
  end

  irq_low: assert property (@(posedge clk) disable iff (rst)
    ack_wr || !irq_pending |=> !core_irq) else begin
    $error("core_irq high after an ack or with no unmasked source");
    fail_count++;
  end

  ack_pulses: assert property (@(posedge clk) disable iff (rst)
    (poke_int_ack == (ack_wr && io_req.wdata[irq_poke_bit])) &&
    (evict_int_ack == (ack_wr && io_req.wdata[irq_evict_bit]))) else begin
    $error("ack pulses do not match the ack write");
    fail_count++;
  end

endmodule

bind core_io_top core_io_assertions i_assertions (
  .clk            (clk),
  .rst            (rst),
  .io_req         (io_req),
  .io_cmd_ready   (io_cmd_ready),
  .io_rsp_valid   (io_rsp_valid),
  .in_desc_taken  (in_desc_taken),
  .out_desc_valid (out_desc_valid),
  .out_desc_ready (out_desc_ready),
  .flags          (flags),
  .timer_irq      (timer_irq),
  .in_desc_valid  (in_desc_valid),
  .poke_int       (poke_int),
  .evict_int      (evict_int),
  .irq_mask       (irq_mask),
  .core_irq       (core_irq),
  .poke_int_ack   (poke_int_ack),
  .evict_int_ack  (evict_int_ack)
);

//--- test/core_io_tb.sv
`timescale 1ns/1ps

module core_io_tb;

  import io_map_pkg::*;
  import io_bus_pkg::*;

  // Tests take a few hundred cycles
  localparam int max_cycles = 3000;

  logic       clk;
  logic       rst;
  io_req_t    io_req;
  logic       io_cmd_ready;
  logic       io_rsp_valid;
  word_t      io_rsp_data;
  desc_t      in_desc;
  logic       in_desc_valid;
  logic       in_desc_taken;
  desc_t      out_desc;
  logic       out_desc_valid;
  dram_addr_t out_desc_dram_addr;
  logic       out_desc_ready;
  core_id_t   core_id;
  timer_val_t timer;
  dram_tag_t  recv_dram_tag;
  logic       recv_dram_tag_valid;
  logic       poke_int;
  logic       evict_int;
  logic       poke_int_ack;
  logic       evict_int_ack;
  logic       core_irq;

  integer     seed = 32'h9cbd2698;
  int         errors = 0;
  int         cycle = 0;
  int         taken_count = 0;
  int         poke_ack_count = 0;
  int         evict_ack_count = 0;
  int         step;
  int         last;
  word_t      flags_model;
  word_t      mask_model;
  word_t      data;
  logic [1:0] offset;
  io_size_t   size;
  dram_tag_t  tag;
  desc_t      desc_data;
  dram_addr_t dram_addr;
  logic [3:0] desc_type;

  tb_clock_gen i_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  core_io_top i_dut (
    .clk                 (clk),
    .rst                 (rst),
    .io_req              (io_req),
    .io_cmd_ready        (io_cmd_ready),
    .io_rsp_valid        (io_rsp_valid),
    .io_rsp_data         (io_rsp_data),
    .in_desc             (in_desc),
    .in_desc_valid       (in_desc_valid),
    .in_desc_taken       (in_desc_taken),
    .out_desc            (out_desc),
    .out_desc_valid      (out_desc_valid),
    .out_desc_dram_addr  (out_desc_dram_addr),
    .out_desc_ready      (out_desc_ready),
    .core_id             (core_id),
    .timer               (timer),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .poke_int            (poke_int),
    .evict_int           (evict_int),
    .poke_int_ack        (poke_int_ack),
    .evict_int_ack       (evict_int_ack),
    .core_irq            (core_irq)
  );

  // Cycle count and pulse counters
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (in_desc_taken) begin
      taken_count <= taken_count + 1;
    end
    if (poke_int_ack) begin
      poke_ack_count <= poke_ack_count + 1;
    end
    if (evict_int_ack) begin
      evict_ack_count <= evict_ack_count + 1;
    end
  end

  always @(posedge clk) begin
    if (cycle >= max_cycles) begin
      $display("Timeout: tests still running after %0d cycles", max_cycles);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus tasks and checks
  ////////////////////////////////////////////////////////////

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Holds the request until an edge with io_cmd_ready high
  task automatic bus_write(input io_addr_t waddr, input logic [1:0] ofs,
                           input io_size_t sz, input word_t wdata);
    io_req.valid = 1'b1;
    io_req.write = 1'b1;
    io_req.addr  = {waddr, ofs};
    io_req.wdata = wdata;
    io_req.size  = sz;
    @(posedge clk);
    while (!io_cmd_ready) begin
      @(posedge clk);
    end
    #1;
    io_req.valid = 1'b0;
    io_req.write = 1'b0;
  endtask

  task automatic bus_read(input io_addr_t raddr, output word_t rdata);
    io_req.valid = 1'b1;
    io_req.write = 1'b0;
    io_req.addr  = {raddr, 2'b00};
    io_req.size  = 2'd2;
    idle(1);
    io_req.valid = 1'b0;
    while (!io_rsp_valid) begin
      idle(1);
    end
    rdata = io_rsp_data;
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_read(input io_addr_t raddr, input string name, input word_t exp);
    word_t rdata;
    bus_read(raddr, rdata);
    check_value(name, {32'd0, rdata}, {32'd0, exp});
  endtask

  task automatic send_tag(input dram_tag_t t);
    recv_dram_tag       = t;
    recv_dram_tag_valid = 1'b1;
    idle(1);
    recv_dram_tag_valid = 1'b0;
  endtask

  // Byte lanes selected by size and offset take the new data
  function automatic word_t merge_lanes(input word_t old, input word_t wdata,
                                        input logic [1:0] ofs, input io_size_t sz);
    word_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (sz == 2'd2 || i == int'(ofs) || (sz == 2'd1 && i == int'(ofs) + 1)) begin
        res[i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic word_t expected_int_flags(input logic timer_flag);
    word_t f;
    f                  = '0;
    f[irq_timer_bit]   = timer_flag;
    f[irq_in_desc_bit] = in_desc_valid;
    f[irq_dram_bit]    = |flags_model;
    f[irq_poke_bit]    = poke_int;
    f[irq_evict_bit]   = evict_int;
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    io_req              = '0;
    in_desc             = {$random(seed), $random(seed)};
    in_desc_valid       = 1'b1;
    out_desc_ready      = 1'b1;
    core_id             = 8'($random(seed));
    timer               = {$random(seed), $random(seed)};
    recv_dram_tag       = '0;
    recv_dram_tag_valid = 1'b0;
    poke_int            = 1'b0;
    evict_int           = 1'b0;
    flags_model         = '0;
    @(negedge rst);

    // Reset values and read-only inputs
    check_read(rd_mask, "irq_mask", 32'h0000_fff0);
    check_read(rd_d_flags_addr, "flags", 32'd0);
    check_read(rd_id_addr, "core_id", {24'd0, core_id});
    check_read(rd_timer_l_addr, "timer_l", timer[31:0]);
    check_read(rd_timer_h_addr, "timer_h", timer[63:32]);
    check_read(rd_stat_addr, "status", 32'h0000_0101);
    check_read(rd_desc_addr_l, "in_desc_l", in_desc[31:0]);
    check_read(rd_desc_addr_h, "in_desc_h", in_desc[63:32]);
    // Byte, half-word and word lanes on the mask
    mask_model = 32'h0000_fff0;
    for (int i = 0; i < 6; i++) begin
      data   = $random(seed);
      offset = 2'($random(seed));
      size   = io_size_t'(i % 3);
      if (size == 2'd1) begin
        offset[0] = 1'b0;
      end
      bus_write(mask_wr, offset, size, data);
      mask_model        = merge_lanes(mask_model, data, offset, size);
      mask_model[31:16] = '0;
      check_read(rd_mask, "irq_mask", mask_model);
    end
    // Byte and half-word lanes on the flag register
    for (int i = 0; i < 6; i++) begin
      data   = $random(seed);
      offset = 2'($random(seed));
      size   = io_size_t'(i % 2);
      if (size == 2'd1) begin
        offset[0] = 1'b0;
      end
      bus_write(dram_flag_addr, offset, size, data);
      flags_model    = merge_lanes(flags_model, data, offset, size);
      flags_model[0] = 1'b0;
      check_read(rd_d_flags_addr, "flags", flags_model);
    end

    // Descriptor send that is first blocked by out_desc_ready
    desc_data = {$random(seed), $random(seed)};
    dram_addr = {$random(seed), $random(seed)};
    desc_type = 4'($random(seed));
    bus_write(send_desc_addr_l, 2'd0, 2'd2, desc_data[31:0]);
    bus_write(send_desc_addr_h, 2'd0, 2'd2, desc_data[63:32]);
    bus_write(wr_dram_addr_l, 2'd0, 2'd2, dram_addr[31:0]);
    bus_write(wr_dram_addr_h, 2'd0, 2'd2, dram_addr[63:32]);
    out_desc_ready = 1'b0;
    io_req.valid   = 1'b1;
    io_req.write   = 1'b1;
    io_req.addr    = {send_desc_type, 2'b00};
    io_req.wdata   = {28'd0, desc_type};
    io_req.size    = 2'd2;
    idle(3);
    check_bit("out_desc_valid", out_desc_valid, 1'b0);
    out_desc_ready = 1'b1;
    idle(1);
    io_req.valid   = 1'b0;
    io_req.write   = 1'b0;
    out_desc_ready = 1'b0;
    idle(3);
    check_bit("out_desc_valid", out_desc_valid, 1'b1);
    check_value("out_desc", out_desc, {desc_type, desc_data[59:0]});
    check_value("out_desc_dram_addr", out_desc_dram_addr, dram_addr);
    out_desc_ready = 1'b1;
    idle(1);
    while (out_desc_valid) begin
      idle(1);
    end
    bus_write(rd_desc_strb, 2'd0, 2'd2, 32'd1);
    bus_write(rd_desc_strb, 2'd0, 2'd2, 32'd0);
    check_value("in_desc_taken pulses", 64'(taken_count), 64'd1);

    // DRAM flags from tags
    bus_write(dram_flag_addr, 2'd0, 2'd2, 32'd0);
    flags_model = '0;
    for (int i = 0; i < 5; i++) begin
      tag = 5'($random(seed));
      send_tag(tag);
      idle(1);
      flags_model[tag] = 1'b1;
      flags_model[0]   = 1'b0;
      check_read(rd_d_flags_addr, "flags", flags_model);
    end
    send_tag(5'd0);
    idle(1);
    check_read(rd_d_flags_addr, "flags", flags_model);
    tag = 5'($random(seed)) | 5'd1;
    send_tag(tag);
    idle(1);
    flags_model[tag] = 1'b1;
    check_read(rd_d_flags_addr, "flags", flags_model);
    bus_write(dram_flag_rst, 2'd0, 2'd2, {27'd0, tag});
    flags_model[tag] = 1'b0;
    check_read(rd_d_flags_addr, "flags", flags_model);
    // Set and clear of one bit meet on the same edge
    tag = 5'($random(seed)) | 5'd1;
    send_tag(tag);
    bus_write(dram_flag_rst, 2'd0, 2'd2, {27'd0, tag});
    flags_model[tag] = 1'b1;
    check_read(rd_d_flags_addr, "flags", flags_model);

    // Timer period of step+1 cycles
    bus_write(mask_wr, 2'd0, 2'd2, 32'h1 << irq_timer_bit);
    step = 5 + ($random(seed) & 7);
    bus_write(timer_stp_addr, 2'd0, 2'd2, word_t'(step));
    last = cycle;
    for (int i = 0; i < 3; i++) begin
      idle(1);
      while (!i_dut.timer_irq) begin
        idle(1);
      end
      check_value("timer interval", 64'(cycle - last), 64'(step + 1));
      last = cycle;
      check_read(rd_int_f_addr, "int_flags", expected_int_flags(1'b1));
      bus_write(interrupt_ack, 2'd0, 2'd2, 32'h1 << irq_timer_bit);
    end

    // Poke and evict through the mask and dropped by an ack
    bus_write(mask_wr, 2'd0, 2'd2, 32'h1 << irq_poke_bit);
    poke_int = 1'b1;
    idle(2);
    check_bit("core_irq", core_irq, 1'b1);
    bus_write(interrupt_ack, 2'd0, 2'd2, 32'h1 << irq_poke_bit);
    check_bit("core_irq", core_irq, 1'b0);
    poke_int = 1'b0;
    idle(2);
    check_bit("core_irq", core_irq, 1'b0);
    bus_write(mask_wr, 2'd0, 2'd2, 32'h1 << irq_evict_bit);
    evict_int = 1'b1;
    idle(2);
    check_bit("core_irq", core_irq, 1'b1);
    bus_write(interrupt_ack, 2'd0, 2'd2, 32'h1 << irq_evict_bit);
    check_bit("core_irq", core_irq, 1'b0);
    evict_int = 1'b0;
    check_value("poke_int_ack pulses", 64'(poke_ack_count), 64'd1);
    check_value("evict_int_ack pulses", 64'(evict_ack_count), 64'd1);

    // DRAM flag source and then everything masked
    bus_write(mask_wr, 2'd0, 2'd2, 32'h1 << irq_dram_bit);
    idle(2);
    check_bit("core_irq", core_irq, 1'b1);
    bus_write(mask_wr, 2'd0, 2'd2, 32'd0);
    poke_int = 1'b1;
    idle(2);
    check_bit("core_irq", core_irq, 1'b0);
    poke_int = 1'b0;
    idle(2);

    $display("Check failures: %0d in testbench, %0d in assertions",
             errors, i_dut.i_assertions.fail_count);
    if (errors == 0 && i_dut.i_assertions.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for 8 cycles, released just after an edge
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule
